/* Bender.yml */
package:
  name: ppu_background

sources:
  - source/ppu_pkg.sv
  - source/entry_buffer_if.sv
  - source/entry_buffer.sv
  - source/palette_fetch.sv
  - source/tile_entry_decode.sv
  - source/line_fetch.sv
  - source/pixel_output.sv
  - source/ppu_background.sv
  - target: test
    files:
      - bench/ppu_background_checker.sv
      - bench/ppu_background_tb.sv

/* bench/ppu_background_checker.sv */
module ppu_background_checker (
    input logic        clk,
    input logic        reset,
    input logic        vblank,
    input logic        hsync,
    input logic [23:0] pixel_color,
    input logic [2:0]  addr_color_palettes,
    input logic [8:0]  addr_tile_buffer
);
    timeunit 1ns;
    timeprecision 1ps;

    int   failures = 0; // Read by the testbench top
    logic loaded_q;     // A palette load has started

    always @(posedge clk) begin
        if (reset) begin
            loaded_q <= 1'b0;
        end else if (vblank) begin
            loaded_q <= 1'b1;
        end
    end

    // Output is blanked one cycle after any blanking input
    blank_after_sync: assert property (@(posedge clk)
        (reset || vblank || hsync) |=> pixel_color == '0)
        else begin
            failures++;
            $error("pixel_color not zero after reset, vblank or hsync");
        end

    // Palette address parks at zero outside vblank
    palette_addr_idle: assert property (@(posedge clk) disable iff (reset)
        (loaded_q && !vblank) |-> addr_color_palettes == '0)
        else begin
            failures++;
            $error("addr_color_palettes moved outside vblank");
        end

    map_addr_range: assert property (@(posedge clk) disable iff (reset)
        hsync |-> addr_tile_buffer < 9'd300)
        else begin
            failures++;
            $error("addr_tile_buffer past the end of the tile map");
        end

endmodule

bind ppu_background ppu_background_checker u_checker (
    .clk                 (clk),
    .reset               (reset),
    .vblank              (vblank),
    .hsync               (hsync),
    .pixel_color         (pixel_color),
    .addr_color_palettes (addr_color_palettes),
    .addr_tile_buffer    (addr_tile_buffer)
);

/* bench/ppu_background_tb.sv */
module ppu_background_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LINE_TILES    = 40;
    localparam int WORDS_PER_ROW = LINE_TILES / 4;
    localparam int MAP_WORDS     = 300;

    logic        clk = 1'b0;
    logic        reset;
    logic [10:0] hcount;
    logic [9:0]  vcount;
    logic        vblank;
    logic        hsync;
    logic [23:0] pixel_color;
    logic [8:0]  addr_tile_buffer;
    logic [31:0] read_data_tile_buffer;
    logic [10:0] addr_tile_graphics;
    logic [31:0] read_data_tile_graphics;
    logic [2:0]  addr_color_palettes;
    logic [23:0] read_data_color_palettes;

    logic [31:0] map_mem [MAP_WORDS];
    logic [31:0] gfx_mem [2048];
    logic [23:0] pal_mem [8];
    integer      seed = 32'h7f7a_5b88;
    logic        show;  // hcount is a displayed pixel of a fetched line

    // Previous cycle as seen by the compare process
    logic        p_valid = 1'b0;
    logic        p_show;
    logic        p_blank;
    int          p_h;
    int          p_v;

    always #4 clk = ~clk;

    ppu_background #(.LINE_TILES(LINE_TILES)) u_ppu_background (.*);

    // Registered reads with data one cycle after the address
    always @(posedge clk) begin
        read_data_tile_buffer    <= map_mem[addr_tile_buffer];
        read_data_tile_graphics  <= gfx_mem[addr_tile_graphics];
        read_data_color_palettes <= pal_mem[addr_color_palettes];
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "Run stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("FAILED at %0d ns: %s = 0x%0h, expected 0x%0h",
                                        $time, name, actual, expected));
        end
    endtask

    // Color of pixel (h, v) from the map, graphics and palette layout rules
    function automatic logic [23:0] expected_color(input int h, input int v);
        int          tile;
        logic [31:0] word;
        logic [7:0]  entry;
        logic [31:0] gfx;
        logic [1:0]  pix;
        tile  = h / 16;
        word  = map_mem[(v / 16) * WORDS_PER_ROW + tile / 4];
        entry = word[8 * (tile % 4) +: 8];   // Entry k in byte k
        gfx   = gfx_mem[entry[6:0] * 16 + v % 16];
        pix   = gfx[31 - 2 * (h % 16) -: 2]; // Pixel 0 at the top bits
        return pal_mem[entry[7] * 4 + pix];
    endfunction

    task automatic run_vblank();
        bit seen;
        seen = 1'b0;
        @(posedge clk);
        vblank <= 1'b1;
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            if (addr_color_palettes == 3'd7) seen = 1'b1;
            @(posedge clk);
        end
        vblank <= 1'b0;
        if (!seen) stop_with_failure("Palette load never reached the last entry during vblank");
    endtask

    task automatic run_line(input int v);
        bit         seen;
        bit         gfx_seen;
        logic [7:0] last_entry;
        seen       = 1'b0;
        gfx_seen   = 1'b0;
        // Map entry of the last tile on the line
        last_entry = map_mem[(v / 16) * WORDS_PER_ROW + WORDS_PER_ROW - 1][31:24];
        @(posedge clk);
        vcount <= 10'(v);
        hsync  <= 1'b1;
        for (int i = 0; i < 64; i++) begin
            @(negedge clk);
            if (addr_tile_buffer == 9'((v / 16) * WORDS_PER_ROW + WORDS_PER_ROW - 1)) seen = 1'b1;
            if (addr_tile_graphics == 11'(last_entry[6:0] * 16 + v % 16)) gfx_seen = 1'b1;
            @(posedge clk);
        end
        hsync  <= 1'b0;
        show   <= 1'b1;
        hcount <= '0;
        for (int h = 1; h < 640; h++) begin
            @(posedge clk);
            hcount <= 11'(h);
        end
        @(posedge clk);
        show   <= 1'b0;
        hcount <= '0;
        if (!seen) stop_with_failure($sformatf("Line %0d fetch never reached its last map word", v));
        if (!gfx_seen) begin
            stop_with_failure($sformatf("Line %0d fetch never requested its last tile row", v));
        end
    endtask

    // Each output is compared with the inputs of the cycle before
    always @(negedge clk) begin : compare_pixels
        if (p_valid) begin
            if (p_blank) begin
                check_value("pixel_color", pixel_color, '0);
            end else if (p_show) begin
                check_value("pixel_color", pixel_color, expected_color(p_h, p_v));
            end
        end
        p_valid = 1'b1;
        p_show  = show;
        p_blank = reset || vblank || hsync;
        p_h     = hcount;
        p_v     = vcount;
    end

    always @(negedge clk) begin
        if (u_ppu_background.u_checker.failures != 0) begin
            stop_with_failure("A bound assertion on the DUT failed");
        end
    end

    initial begin : watchdog
        #100_000;
        stop_with_failure("Simulation ran past its time limit");
    end

    initial begin
        reset                    = 1'b1;
        hcount                   = '0;
        vcount                   = '0;
        vblank                   = 1'b0;
        hsync                    = 1'b0;
        show                     = 1'b0;
        read_data_tile_buffer    = '0;
        read_data_tile_graphics  = '0;
        read_data_color_palettes = '0;
        for (int i = 0; i < MAP_WORDS; i++) begin
            map_mem[i] = $random(seed);
            map_mem[i][7]  = 1'b0; // Entry 0 uses the lower palette half
            map_mem[i][15] = 1'b1; // Entry 1 uses the upper half
        end
        for (int i = 0; i < 2048; i++) gfx_mem[i] = $random(seed);
        for (int i = 0; i < 8; i++) pal_mem[i] = 24'($random(seed));

        repeat (2) @(posedge clk);
        reset <= 1'b0;

        run_vblank();
        run_line(0);
        run_line(5);
        run_line(17);
        run_line(479);

        // New colors take effect only at the next vblank
        repeat (2) @(negedge clk);
        for (int i = 0; i < 8; i++) pal_mem[i] = 24'($random(seed));
        run_vblank();
        run_line(200);

        repeat (2) @(negedge clk);
        if (u_ppu_background.u_checker.failures != 0) begin
            stop_with_failure("A bound assertion on the DUT failed");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

/* compile.f */
source/ppu_pkg.sv
source/entry_buffer_if.sv
source/entry_buffer.sv
source/palette_fetch.sv
source/tile_entry_decode.sv
source/line_fetch.sv
source/pixel_output.sv
source/ppu_background.sv
bench/ppu_background_checker.sv
bench/ppu_background_tb.sv

/* source/entry_buffer.sv */
module entry_buffer
    import ppu_pkg::*;
#(
    parameter type entry_t = color_t,
    parameter int  DEPTH   = PALETTE_ENTRIES
) (
    input logic           clk,
    input logic           reset,
    entry_buffer_if.store bus
);

    entry_t entries_q [DEPTH];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                entries_q[i] <= '0;
            end
        end else if (bus.write_en) begin
            entries_q[bus.write_index] <= bus.write_data;
        end
    end

    // Read is combinational so a stage can use the entry in the same cycle
    assign bus.read_data = entries_q[bus.read_index];

endmodule

/* source/entry_buffer_if.sv */
interface entry_buffer_if #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = 2
);

    logic                     write_en;
    logic [$clog2(DEPTH)-1:0] write_index;
    entry_t                   write_data;
    logic [$clog2(DEPTH)-1:0] read_index;
    entry_t                   read_data; // Follows read_index combinationally

    modport writer (
        output write_en, write_index, write_data
    );

    modport reader (
        output read_index,
        input  read_data
    );

    // Store side sees both ports mirrored
    modport store (
        input  write_en, write_index, write_data, read_index,
        output read_data
    );

endinterface

/* source/line_fetch.sv */
module line_fetch
    import ppu_pkg::*;
#(
    parameter int LINE_TILES = 40
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           hsync,
    input  logic           vblank,
    input  logic [9:0]     vcount,
    output map_addr_t      addr_tile_buffer,
    input  map_word_t      read_data_tile_buffer,
    output gfx_addr_t      addr_tile_graphics,
    input  gfx_word_t      read_data_tile_graphics,
    entry_buffer_if.writer line_wr
);

    localparam int WORDS_PER_ROW = LINE_TILES / ENTRIES_PER_WORD;
    localparam int CNT_W         = $clog2(LINE_TILES + 1);
    localparam int IDX_W         = $clog2(LINE_TILES);

    logic [CNT_W-1:0]        tile_q;     // Tile whose map word is requested next
    logic                    run;
    logic                    issue_q;
    logic [1:0]              lane_q;
    logic [3:0]              fine_q;
    logic [3:0][CNT_W-1:0]   tile_pipe;  // Tile index delayed one slot per pipeline cycle
    logic                    palette_sel;
    logic                    decoded;
    logic                    row_palette_q;
    logic                    wr_valid_q;
    tile_row_t               row;

    assign run = hsync && !vblank && (tile_q < LINE_TILES);

    always_ff @(posedge clk) begin
        if (reset) begin
            tile_q           <= '0;
            addr_tile_buffer <= '0;
            issue_q          <= 1'b0;
            wr_valid_q       <= 1'b0;
        end else begin
            issue_q    <= run;
            wr_valid_q <= hsync && decoded;
            if (run) begin
                // Tile row base plus word offset within the row
                addr_tile_buffer <= map_addr_t'(vcount / TILE_SIZE) * map_addr_t'(WORDS_PER_ROW)
                                    + map_addr_t'(tile_q / ENTRIES_PER_WORD);
                tile_q           <= tile_q + 1'b1;
            end else begin
                addr_tile_buffer <= '0;
                if (!hsync) begin
                    tile_q <= '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        lane_q        <= 2'(tile_q % ENTRIES_PER_WORD);
        fine_q        <= 4'(vcount % TILE_SIZE);
        tile_pipe     <= {tile_pipe[2:0], tile_q};
        row_palette_q <= palette_sel; // Lines up with the returning graphics row
    end

    tile_entry_decode u_tile_entry_decode (
        .clk         (clk),
        .reset       (reset),
        .issue       (issue_q),
        .lane        (lane_q),
        .fine_row    (fine_q),
        .map_word    (read_data_tile_buffer),
        .gfx_addr    (addr_tile_graphics),
        .palette_sel (palette_sel),
        .decoded     (decoded)
    );

    assign row.palette_sel = row_palette_q;
    assign row.gfx         = read_data_tile_graphics;

    assign line_wr.write_en    = wr_valid_q;
    assign line_wr.write_index = IDX_W'(tile_pipe[3]);
    assign line_wr.write_data  = row;

endmodule

/* source/palette_fetch.sv */
module palette_fetch
    import ppu_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            vblank,
    output palette_addr_t   addr_color_palettes,
    input  color_t          read_data_color_palettes,
    entry_buffer_if.writer  palette_wr
);

    localparam int COUNT_W = $clog2(PALETTE_ENTRIES + 1);

    logic [COUNT_W-1:0] count_q;      // Next palette entry to request
    logic               addr_valid_q; // addr_color_palettes holds a real request
    logic               wr_valid_q;   // Memory data for wr_addr_q is on the bus
    palette_addr_t      wr_addr_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            count_q             <= '0;
            addr_color_palettes <= '0;
            addr_valid_q        <= 1'b0;
            wr_valid_q          <= 1'b0;
        end else begin
            wr_valid_q <= addr_valid_q;
            if (vblank && count_q < PALETTE_ENTRIES) begin
                addr_color_palettes <= palette_addr_t'(count_q);
                count_q             <= count_q + 1'b1;
                addr_valid_q        <= 1'b1;
            end else begin
                addr_color_palettes <= '0; // Park the address when idle
                addr_valid_q        <= 1'b0;
                if (!vblank) begin
                    count_q <= '0;
                end
            end
        end
    end

    // Address of the color now returning from memory
    always_ff @(posedge clk) begin
        wr_addr_q <= addr_color_palettes;
    end

    assign palette_wr.write_en    = wr_valid_q;
    assign palette_wr.write_index = wr_addr_q;
    assign palette_wr.write_data  = read_data_color_palettes;

endmodule

/* source/pixel_output.sv */
module pixel_output
    import ppu_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  logic [10:0]    hcount,
    input  logic           vblank,
    input  logic           hsync,
    entry_buffer_if.reader line_rd,
    entry_buffer_if.reader palette_rd,
    output color_t         pixel_color
);

    localparam int LINE_IDX_W = $bits(line_rd.read_index);

    tile_row_t                  row;
    pixel_t [TILE_SIZE-1:0]     pixels;   // Pixel 0 sits at the top index
    logic [3:0]                 fine_col; // Column within the tile
    pixel_t                     pixel;

    // Tile under the beam
    assign line_rd.read_index = LINE_IDX_W'(hcount / TILE_SIZE);
    assign row                = line_rd.read_data;

    assign pixels   = row.gfx;
    assign fine_col = 4'(hcount % TILE_SIZE);
    assign pixel    = pixels[4'(TILE_SIZE - 1) - fine_col];

    // Palette select picks the upper or lower half of the palette store
    assign palette_rd.read_index = palette_addr_t'(row.palette_sel)
                                   * palette_addr_t'(COLORS_PER_PALETTE)
                                   + palette_addr_t'(pixel);

    always_ff @(posedge clk) begin
        if (reset || vblank || hsync) begin
            pixel_color <= '0; // Blank outside the active region
        end else begin
            pixel_color <= palette_rd.read_data;
        end
    end

endmodule

/* source/ppu_background.sv */
module ppu_background
    import ppu_pkg::*;
#(
    parameter int LINE_TILES = 40
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [10:0] hcount,
    input  logic [9:0]  vcount,
    input  logic        vblank,
    input  logic        hsync,
    output logic [23:0] pixel_color,

    // Tile map memory
    output logic [8:0]  addr_tile_buffer,
    input  logic [31:0] read_data_tile_buffer,

    // Tile graphics memory
    output logic [10:0] addr_tile_graphics,
    input  logic [31:0] read_data_tile_graphics,

    // Color palette memory
    output logic [2:0]  addr_color_palettes,
    input  logic [23:0] read_data_color_palettes
);

    // Palette colors loaded once per frame
    entry_buffer_if #(.entry_t(color_t), .DEPTH(PALETTE_ENTRIES)) palette_bus ();

    // Tile rows of the current line loaded during hsync
    entry_buffer_if #(.entry_t(tile_row_t), .DEPTH(LINE_TILES)) line_bus ();

    entry_buffer #(
        .entry_t (color_t),
        .DEPTH   (PALETTE_ENTRIES)
    ) u_palette_store (
        .clk   (clk),
        .reset (reset),
        .bus   (palette_bus.store)
    );

    entry_buffer #(
        .entry_t (tile_row_t),
        .DEPTH   (LINE_TILES)
    ) u_line_store (
        .clk   (clk),
        .reset (reset),
        .bus   (line_bus.store)
    );

    palette_fetch u_palette_fetch (
        .clk                      (clk),
        .reset                    (reset),
        .vblank                   (vblank),
        .addr_color_palettes      (addr_color_palettes),
        .read_data_color_palettes (read_data_color_palettes),
        .palette_wr               (palette_bus.writer)
    );

    line_fetch #(
        .LINE_TILES (LINE_TILES)
    ) u_line_fetch (
        .clk                     (clk),
        .reset                   (reset),
        .hsync                   (hsync),
        .vblank                  (vblank),
        .vcount                  (vcount),
        .addr_tile_buffer        (addr_tile_buffer),
        .read_data_tile_buffer   (read_data_tile_buffer),
        .addr_tile_graphics      (addr_tile_graphics),
        .read_data_tile_graphics (read_data_tile_graphics),
        .line_wr                 (line_bus.writer)
    );

    pixel_output u_pixel_output (
        .clk         (clk),
        .reset       (reset),
        .hcount      (hcount),
        .vblank      (vblank),
        .hsync       (hsync),
        .line_rd     (line_bus.reader),
        .palette_rd  (palette_bus.reader),
        .pixel_color (pixel_color)
    );

endmodule

/* source/ppu_pkg.sv */
package ppu_pkg;

    // Screen geometry
    localparam int TILE_SIZE          = 16; // Tile width and height in pixels
    localparam int ENTRIES_PER_WORD   = 4;  // Map entries packed in one map word
    localparam int PALETTE_ENTRIES    = 8;
    localparam int COLORS_PER_PALETTE = 4;  // Colors per palette select value

    typedef logic [23:0] color_t;    // RGB pixel color
    typedef logic [31:0] map_word_t; // Four map entries with entry 0 in the lowest byte
    typedef logic [31:0] gfx_word_t; // Sixteen 2-bit pixels with pixel 0 at the top

    typedef logic [8:0]  map_addr_t;
    typedef logic [10:0] gfx_addr_t;
    typedef logic [2:0]  palette_addr_t;
    typedef logic [1:0]  pixel_t;

    // One byte of a map word
    typedef struct packed {
        logic       palette_sel;
        logic [6:0] tile_id;
    } tile_entry_t;

    // Line store entry
    typedef struct packed {
        logic      palette_sel;
        gfx_word_t gfx;
    } tile_row_t;

endpackage

/* source/tile_entry_decode.sv */
module tile_entry_decode
    import ppu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       issue,    // Map read on the address port this cycle
    input  logic [1:0] lane,     // Entry within the map word
    input  logic [3:0] fine_row, // Row within the tile
    input  map_word_t  map_word,
    output gfx_addr_t  gfx_addr,
    output logic       palette_sel,
    output logic       decoded
);

    logic                                  issue_q;
    logic [1:0]                            lane_q;
    logic [3:0]                            fine_q;
    tile_entry_t [ENTRIES_PER_WORD-1:0]    entries;
    tile_entry_t                           entry;

    assign entries = map_word; // Entry 0 lands in the lowest byte
    assign entry   = entries[lane_q];

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_q  <= 1'b0;
            decoded  <= 1'b0;
            gfx_addr <= '0;
        end else begin
            issue_q <= issue;
            decoded <= issue_q;
            if (issue_q) begin
                gfx_addr <= gfx_addr_t'(entry.tile_id) * gfx_addr_t'(TILE_SIZE)
                            + gfx_addr_t'(fine_q);
            end else begin
                gfx_addr <= '0;
            end
        end
    end

    // Lane and row travel with the map word, which arrives a cycle after the address
    always_ff @(posedge clk) begin
        lane_q      <= lane;
        fine_q      <= fine_row;
        palette_sel <= entry.palette_sel;
    end

endmodule
